/* riscv_csr_macros.svh */
`ifndef RISCV_CSR_MACROS_SVH
`define RISCV_CSR_MACROS_SVH

// bus widths
`define DATA_W              64
`define INST_W              32
`define CSR_IDX_W           12

// SYSTEM opcode and privileged funct12 values
`define OPC_SYSTEM          7'b1110011
`define FUNCT12_ECALL       12'h000
`define FUNCT12_EBREAK      12'h001
`define FUNCT12_MRET        12'h302

// machine CSR addresses
`define CSR_MSTATUS         12'h300
`define CSR_MISA            12'h301
`define CSR_MIE             12'h304
`define CSR_MTVEC           12'h305
`define CSR_MSCRATCH        12'h340
`define CSR_MEPC            12'h341
`define CSR_MCAUSE          12'h342
`define CSR_MIP             12'h344
`define CSR_MCYCLE          12'hB00
`define CSR_MINSTRET        12'hB02
`define CSR_MVENDORID       12'hF11
`define CSR_MARCHID         12'hF12
`define CSR_MIMPID          12'hF13
`define CSR_MHARTID         12'hF14

// csr_ctrl: bit 2 picks zimm, bits 1:0 the operation
`define CSR_CTRL_IMM        2
`define CSR_OP_NONE         2'b00
`define CSR_OP_RW           2'b01
`define CSR_OP_RS           2'b10
`define CSR_OP_RC           2'b11

// mcause codes
`define CAUSE_ECALL_M       64'd11
`define CAUSE_BREAKPOINT    64'd3
`define CAUSE_MTIMER        64'h8000_0000_0000_0007

// mstatus / mip / mie bit positions
`define MSTATUS_MIE         3
`define MSTATUS_MPIE        7
`define MTIP_BIT            7
`define MTI_MASK            64'h80

// read-only ID values, RV64I
`define MISA_VALUE          64'h8000_0000_0000_0100
`define MVENDORID_VALUE     64'd0
`define MARCHID_VALUE       64'd1
`define MIMPID_VALUE        64'd1
`define MHARTID_VALUE       64'd0

`endif

/* csr_pkg.sv */
`include "riscv_csr_macros.svh"

package csr_pkg;

    // one data word, also used for pc values
    typedef logic [`DATA_W-1:0]    xlen_t;

    // raw instruction word
    typedef logic [`INST_W-1:0]    inst_t;

    // CSR address field
    typedef logic [`CSR_IDX_W-1:0] csr_idx_t;

    // {imm select, op[1:0]}
    typedef logic [2:0]            csr_ctrl_t;

endpackage

/* csr_decode.sv */
`timescale 1ns/10ps
`include "riscv_csr_macros.svh"

module csr_decode (
    input  logic                inst_valid_i,
    input  csr_pkg::inst_t      inst_i,
    input  logic                csr_trap_i,
    output csr_pkg::csr_idx_t   csr_index_o,
    output csr_pkg::csr_ctrl_t  csr_ctrl_o,
    output csr_pkg::xlen_t      imm_csr_o,
    output logic                inst_trap_o,
    output logic                inst_mret_o,
    output logic                inst_ecall_o,
    output logic                inst_ebreak_o,
    output logic                rd_nz_o,
    output logic                intp_en_o
);
    import csr_pkg::*;

    logic      is_system;
    logic      is_csr;
    logic      is_priv;
    csr_ctrl_t funct3;
    csr_idx_t  funct12;
    logic      ecall;
    logic      ebreak;

    assign is_system = inst_i[6:0] == `OPC_SYSTEM;
    assign funct3    = inst_i[14:12];
    assign funct12   = inst_i[31:20];

    // funct3 maps straight onto csr_ctrl, 000 and 100 are not CSR ops
    assign is_csr  = is_system & (funct3[1:0] != `CSR_OP_NONE);
    assign is_priv = is_system & (funct3 == 3'b000);

    assign csr_index_o = is_csr ? funct12 : '0;
    assign csr_ctrl_o  = is_csr ? funct3 : '0;

    // zimm lives in the rs1 field
    assign imm_csr_o = is_csr ? xlen_t'(inst_i[19:15]) : '0;

    assign ecall  = is_priv & (funct12 == `FUNCT12_ECALL);
    assign ebreak = is_priv & (funct12 == `FUNCT12_EBREAK);

    assign inst_ecall_o  = ecall;
    assign inst_ebreak_o = ebreak;
    assign inst_trap_o   = ecall | ebreak;
    assign inst_mret_o   = is_priv & (funct12 == `FUNCT12_MRET);

    assign rd_nz_o = is_csr & (inst_i[11:7] != 5'd0);

    // pending interrupt replaces whatever instruction shows up
    assign intp_en_o = inst_valid_i & csr_trap_i;

endmodule

/* clint_timer.sv */
`timescale 1ns/10ps

module clint_timer (
    input  logic            clk,
    input  logic            rst,
    input  logic            mtimecmp_we_i,
    input  csr_pkg::xlen_t  mtimecmp_data_i,
    output logic            mtip_o,
    output logic            update_o
);
    import csr_pkg::*;

    xlen_t mtime_q;
    xlen_t mtimecmp_q;
    logic  update_q;

    // free-running time base
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + xlen_t'(1);
        end
    end

    // all ones after reset so nothing fires
    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp_q <= '1;
        end else if (mtimecmp_we_i) begin
            mtimecmp_q <= mtimecmp_data_i;
        end
    end

    // one cycle after a compare write, lets mip drop when mtip falls
    always_ff @(posedge clk) begin
        if (rst) begin
            update_q <= 1'b0;
        end else begin
            update_q <= mtimecmp_we_i;
        end
    end

    assign mtip_o   = mtime_q >= mtimecmp_q;
    assign update_o = update_q;

endmodule

/* mem_csr.sv */
`timescale 1ns/10ps
`include "riscv_csr_macros.svh"

module mem_csr (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid_i,
    input  logic                intp_en_i,
    input  csr_pkg::csr_idx_t   csr_index_i,
    input  csr_pkg::xlen_t      rs1_data_i,
    input  csr_pkg::xlen_t      imm_csr_i,
    input  csr_pkg::csr_ctrl_t  csr_ctrl_i,
    input  csr_pkg::xlen_t      inst_addr_i,
    input  logic                inst_trap_i,
    input  logic                inst_mret_i,
    input  logic                clint_mtip_i,
    input  logic                clint_update_i,
    input  logic                inst_ecall_i,
    input  logic                inst_ebreak_i,
    output logic                csr_trap_o,
    output csr_pkg::xlen_t      csr_nxt_pc_o,
    output csr_pkg::xlen_t      csr_read_o
);
    import csr_pkg::*;

    xlen_t mcycle_q;
    xlen_t minstret_q;
    xlen_t mstatus_q;
    xlen_t mtvec_q;
    xlen_t mepc_q;
    xlen_t mcause_q;
    xlen_t mip_q;
    xlen_t mie_q;
    xlen_t mscratch_q;

    xlen_t mcycle_nxt;
    xlen_t minstret_nxt;
    xlen_t csr_old;
    xlen_t csr_src;
    xlen_t csr_new;

    logic  trap_nmret;
    logic  change_en;
    logic  wr_en;
    logic  trap_en;
    logic  ret_en;

    assign trap_nmret = (inst_trap_i & ~inst_mret_i) | intp_en_i;
    assign change_en  = inst_valid_i & ~intp_en_i;
    assign wr_en      = change_en & (csr_ctrl_i[1:0] != `CSR_OP_NONE);
    assign trap_en    = inst_valid_i & trap_nmret;
    assign ret_en     = inst_valid_i & inst_mret_i;

    assign mcycle_nxt   = mcycle_q + xlen_t'(1);
    assign minstret_nxt = minstret_q + xlen_t'(1);

    // operand for rs/rc; the counters use their incremented value
    always_comb begin
        case (csr_index_i)
            `CSR_MCYCLE:   csr_old = mcycle_nxt;
            `CSR_MINSTRET: csr_old = minstret_nxt;
            `CSR_MSTATUS:  csr_old = mstatus_q;
            `CSR_MTVEC:    csr_old = mtvec_q;
            `CSR_MEPC:     csr_old = mepc_q;
            `CSR_MCAUSE:   csr_old = mcause_q;
            `CSR_MIP:      csr_old = mip_q;
            `CSR_MIE:      csr_old = mie_q;
            `CSR_MSCRATCH: csr_old = mscratch_q;
            default:       csr_old = '0;
        endcase
    end

    assign csr_src = csr_ctrl_i[`CSR_CTRL_IMM] ? imm_csr_i : rs1_data_i;

    always_comb begin
        case (csr_ctrl_i[1:0])
            `CSR_OP_RW: csr_new = csr_src;
            `CSR_OP_RS: csr_new = csr_old | csr_src;
            `CSR_OP_RC: csr_new = csr_old & ~csr_src;
            default:    csr_new = csr_old;
        endcase
    end

    // counters
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            if (wr_en && csr_index_i == `CSR_MCYCLE) begin
                mcycle_q <= csr_new;
            end else begin
                mcycle_q <= mcycle_nxt;
            end
            // only an interrupt takeover holds minstret
            if (wr_en && csr_index_i == `CSR_MINSTRET) begin
                minstret_q <= csr_new;
            end else if (!intp_en_i) begin
                minstret_q <= minstret_nxt;
            end
        end
    end

    // mstatus, SD summarizes FS/XS
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q <= '0;
        end else if (wr_en && csr_index_i == `CSR_MSTATUS) begin
            mstatus_q <= {(csr_new[16:15] == 2'b11) | (csr_new[14:13] == 2'b11), csr_new[62:0]};
        end else if (trap_en) begin
            mstatus_q[12:11]         <= 2'b11;
            mstatus_q[`MSTATUS_MPIE] <= mstatus_q[`MSTATUS_MIE];
            mstatus_q[`MSTATUS_MIE]  <= 1'b0;
        end else if (ret_en) begin
            mstatus_q[12:11]         <= 2'b00;
            mstatus_q[`MSTATUS_MPIE] <= 1'b1;
            mstatus_q[`MSTATUS_MIE]  <= mstatus_q[`MSTATUS_MPIE];
        end
    end

    // trap vector and exception state
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mscratch_q <= '0;
        end else begin
            if (wr_en && csr_index_i == `CSR_MTVEC) begin
                mtvec_q <= csr_new & ~xlen_t'(3);
            end
            if (wr_en && csr_index_i == `CSR_MEPC) begin
                mepc_q <= csr_new;
            end else if (trap_en) begin
                mepc_q <= inst_addr_i;
            end
            if (wr_en && csr_index_i == `CSR_MCAUSE) begin
                mcause_q <= csr_new;
            end else if (inst_ecall_i && change_en) begin
                mcause_q <= `CAUSE_ECALL_M;
            end else if (inst_ebreak_i && change_en) begin
                mcause_q <= `CAUSE_BREAKPOINT;
            end else if (trap_en) begin
                // left over: interrupt takeover
                mcause_q <= `CAUSE_MTIMER;
            end
            if (wr_en && csr_index_i == `CSR_MSCRATCH) begin
                mscratch_q <= csr_new;
            end
        end
    end

    // interrupt pending and enable, timer bit only
    always_ff @(posedge clk) begin
        if (rst) begin
            mip_q <= '0;
            mie_q <= '0;
        end else begin
            if (wr_en && csr_index_i == `CSR_MIP) begin
                mip_q <= csr_new & `MTI_MASK;
            end else if (clint_mtip_i || clint_update_i) begin
                mip_q[`MTIP_BIT] <= clint_mtip_i;
            end
            if (wr_en && csr_index_i == `CSR_MIE) begin
                mie_q <= csr_new & `MTI_MASK;
            end
        end
    end

    assign csr_trap_o   = mstatus_q[`MSTATUS_MIE] & mie_q[`MTIP_BIT] & mip_q[`MTIP_BIT];
    assign csr_nxt_pc_o = trap_nmret ? mtvec_q : mepc_q;

    always_comb begin
        case (csr_index_i)
            `CSR_MCYCLE:    csr_read_o = mcycle_q;
            `CSR_MINSTRET:  csr_read_o = minstret_q;
            `CSR_MISA:      csr_read_o = `MISA_VALUE;
            `CSR_MVENDORID: csr_read_o = `MVENDORID_VALUE;
            `CSR_MARCHID:   csr_read_o = `MARCHID_VALUE;
            `CSR_MIMPID:    csr_read_o = `MIMPID_VALUE;
            `CSR_MHARTID:   csr_read_o = `MHARTID_VALUE;
            `CSR_MSTATUS:   csr_read_o = mstatus_q;
            `CSR_MTVEC:     csr_read_o = mtvec_q;
            `CSR_MEPC:      csr_read_o = mepc_q;
            `CSR_MCAUSE:    csr_read_o = mcause_q;
            `CSR_MIP:       csr_read_o = mip_q;
            `CSR_MIE:       csr_read_o = mie_q;
            `CSR_MSCRATCH:  csr_read_o = mscratch_q;
            default:        csr_read_o = '0;
        endcase
    end

endmodule

/* csr_commit.sv */
`timescale 1ns/10ps

module csr_commit (
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_valid_i,
    input  logic            csr_op_i,
    input  logic            rd_nz_i,
    input  logic            redirect_i,
    input  csr_pkg::xlen_t  csr_read_i,
    input  csr_pkg::xlen_t  csr_nxt_pc_i,
    output logic            rd_we_o,
    output csr_pkg::xlen_t  rd_data_o,
    output logic            redirect_o,
    output csr_pkg::xlen_t  redirect_pc_o
);

    // strobes, one cycle behind the instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_we_o    <= 1'b0;
            redirect_o <= 1'b0;
        end else begin
            // a CSR op never traps itself, so a redirect here means takeover
            rd_we_o    <= inst_valid_i & csr_op_i & rd_nz_i & ~redirect_i;
            redirect_o <= inst_valid_i & redirect_i;
        end
    end

    // payload, old CSR value and target pc
    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            rd_data_o     <= csr_read_i;
            redirect_pc_o <= csr_nxt_pc_i;
        end
    end

endmodule

/* csr_subsystem_top.sv */
`timescale 1ns/10ps

module csr_subsystem_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_valid_i,
    input  csr_pkg::inst_t  inst_i,
    input  csr_pkg::xlen_t  inst_addr_i,
    input  csr_pkg::xlen_t  rs1_data_i,
    input  logic            mtimecmp_we_i,
    input  csr_pkg::xlen_t  mtimecmp_data_i,
    output logic            rd_we_o,
    output csr_pkg::xlen_t  rd_data_o,
    output logic            redirect_o,
    output csr_pkg::xlen_t  redirect_pc_o
);
    import csr_pkg::*;

    csr_idx_t  csr_index;
    csr_ctrl_t csr_ctrl;
    xlen_t     imm_csr;
    logic      inst_trap;
    logic      inst_mret;
    logic      inst_ecall;
    logic      inst_ebreak;
    logic      rd_nz;
    logic      intp_en;
    logic      clint_mtip;
    logic      clint_update;
    logic      csr_trap;
    xlen_t     csr_nxt_pc;
    xlen_t     csr_read;
    logic      csr_op;
    logic      redirect_req;

    assign csr_op       = csr_ctrl[1:0] != 2'b00;
    assign redirect_req = inst_trap | inst_mret | intp_en;

    csr_decode u_decode (
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .csr_trap_i    (csr_trap),
        .csr_index_o   (csr_index),
        .csr_ctrl_o    (csr_ctrl),
        .imm_csr_o     (imm_csr),
        .inst_trap_o   (inst_trap),
        .inst_mret_o   (inst_mret),
        .inst_ecall_o  (inst_ecall),
        .inst_ebreak_o (inst_ebreak),
        .rd_nz_o       (rd_nz),
        .intp_en_o     (intp_en)
    );

    clint_timer u_clint (
        .clk             (clk),
        .rst             (rst),
        .mtimecmp_we_i   (mtimecmp_we_i),
        .mtimecmp_data_i (mtimecmp_data_i),
        .mtip_o          (clint_mtip),
        .update_o        (clint_update)
    );

    mem_csr u_mem_csr (
        .clk            (clk),
        .rst            (rst),
        .inst_valid_i   (inst_valid_i),
        .intp_en_i      (intp_en),
        .csr_index_i    (csr_index),
        .rs1_data_i     (rs1_data_i),
        .imm_csr_i      (imm_csr),
        .csr_ctrl_i     (csr_ctrl),
        .inst_addr_i    (inst_addr_i),
        .inst_trap_i    (inst_trap),
        .inst_mret_i    (inst_mret),
        .clint_mtip_i   (clint_mtip),
        .clint_update_i (clint_update),
        .inst_ecall_i   (inst_ecall),
        .inst_ebreak_i  (inst_ebreak),
        .csr_trap_o     (csr_trap),
        .csr_nxt_pc_o   (csr_nxt_pc),
        .csr_read_o     (csr_read)
    );

    csr_commit u_commit (
        .clk           (clk),
        .rst           (rst),
        .inst_valid_i  (inst_valid_i),
        .csr_op_i      (csr_op),
        .rd_nz_i       (rd_nz),
        .redirect_i    (redirect_req),
        .csr_read_i    (csr_read),
        .csr_nxt_pc_i  (csr_nxt_pc),
        .rd_we_o       (rd_we_o),
        .rd_data_o     (rd_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

/* tb_csr_checker.sv */
`timescale 1ns/10ps
`include "riscv_csr_macros.svh"

module tb_csr_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid_i,
    input  logic [`INST_W-1:0]  inst_i,
    input  logic [`DATA_W-1:0]  inst_addr_i,
    input  logic [`DATA_W-1:0]  rs1_data_i,
    input  logic                mtimecmp_we_i,
    input  logic [`DATA_W-1:0]  mtimecmp_data_i,
    input  logic                rd_we_i,
    input  logic [`DATA_W-1:0]  rd_data_i,
    input  logic                redirect_i,
    input  logic [`DATA_W-1:0]  redirect_pc_i,
    output int                  errors_o,
    output int                  checks_o
);

    // reference state
    logic [63:0] mcycle;
    logic [63:0] minstret;
    logic [63:0] mstatus;
    logic [63:0] mtvec;
    logic [63:0] mepc;
    logic [63:0] mcause;
    logic [63:0] mip;
    logic [63:0] mie;
    logic [63:0] mscratch;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        tmr_update;

    // what the outputs must show one cycle later
    logic        armed = 1'b0;
    logic        exp_rd_we;
    logic        exp_redirect;
    logic [63:0] exp_rd_data;
    logic [63:0] exp_pc;
    string       exp_name;

    int err_count = 0;
    int chk_count = 0;

    assign errors_o = err_count;
    assign checks_o = chk_count;

    function automatic logic [63:0] csr_value(input logic [11:0] idx);
        case (idx)
            `CSR_MCYCLE:    return mcycle;
            `CSR_MINSTRET:  return minstret;
            `CSR_MISA:      return `MISA_VALUE;
            `CSR_MARCHID:   return 64'd1;
            `CSR_MIMPID:    return 64'd1;
            `CSR_MSTATUS:   return mstatus;
            `CSR_MTVEC:     return mtvec;
            `CSR_MEPC:      return mepc;
            `CSR_MCAUSE:    return mcause;
            `CSR_MIP:       return mip;
            `CSR_MIE:       return mie;
            `CSR_MSCRATCH:  return mscratch;
            default:        return 64'd0;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        chk_count++;
        if (expected !== actual) begin
            err_count++;
            $display("** Error %s, %s: expected %h, actual %h (t=%0t)",
                     exp_name, what, expected, actual, $time);
        end
    endtask

    always @(posedge clk) begin : model_step
        logic [2:0]  funct3;
        logic [11:0] idx;
        logic        sys;
        logic        csr_op;
        logic        ecall;
        logic        ebreak;
        logic        mret;
        logic        take;
        logic        trap;
        logic        mtip;
        logic        wr;
        logic [63:0] src;
        logic [63:0] old;
        logic [63:0] nv;
        logic [63:0] st;
        if (rst) begin
            mcycle       = '0;
            minstret     = '0;
            mstatus      = '0;
            mtvec        = '0;
            mepc         = '0;
            mcause       = '0;
            mip          = '0;
            mie          = '0;
            mscratch     = '0;
            mtime        = '0;
            mtimecmp     = '1;
            tmr_update   = 1'b0;
            exp_rd_we    = 1'b0;
            exp_redirect = 1'b0;
            exp_name     = "reset";
            armed        = 1'b1;
        end else begin
            funct3 = inst_i[14:12];
            idx    = inst_i[31:20];
            sys    = inst_i[6:0] == `OPC_SYSTEM;
            csr_op = sys && funct3[1:0] != 2'b00;
            ecall  = sys && funct3 == 3'b000 && idx == 12'h000;
            ebreak = sys && funct3 == 3'b000 && idx == 12'h001;
            mret   = sys && funct3 == 3'b000 && idx == 12'h302;
            // pending timer interrupt steals the instruction
            take   = inst_valid_i && mstatus[3] && mie[7] && mip[7];
            trap   = inst_valid_i && (ecall || ebreak || take);
            mtip   = mtime >= mtimecmp;

            exp_rd_we    = inst_valid_i && csr_op && inst_i[11:7] != 5'd0 && !take;
            exp_redirect = trap || (inst_valid_i && mret);
            if (!inst_valid_i) begin
                exp_name = "idle";
            end else begin
                exp_rd_data = csr_value(idx);
                exp_pc      = (ecall || ebreak || take) ? mtvec : mepc;
                if (take) begin
                    exp_name = "interrupt takeover";
                end else if (ecall) begin
                    exp_name = "ecall";
                end else if (ebreak) begin
                    exp_name = "ebreak";
                end else if (mret) begin
                    exp_name = "mret";
                end else if (csr_op) begin
                    exp_name = $sformatf("csr op f3=%0d on %03h", funct3, idx);
                end else begin
                    exp_name = "non-system";
                end
            end

            src = funct3[2] ? {59'd0, inst_i[19:15]} : rs1_data_i;
            old = csr_value(idx);
            case (funct3[1:0])
                2'b01:   nv = src;
                2'b10:   nv = old | src;
                default: nv = old & ~src;
            endcase
            wr = inst_valid_i && csr_op && !take;

            if (wr && idx == `CSR_MSCRATCH) begin
                mscratch = nv;
            end
            if (wr && idx == `CSR_MTVEC) begin
                mtvec = {nv[63:2], 2'b00};
            end
            if (wr && idx == `CSR_MEPC) begin
                mepc = nv;
            end else if (trap) begin
                mepc = inst_addr_i;
            end
            if (wr && idx == `CSR_MCAUSE) begin
                mcause = nv;
            end else if (trap) begin
                mcause = take ? `CAUSE_MTIMER : (ecall ? 64'd11 : 64'd3);
            end
            if (wr && idx == `CSR_MIE) begin
                mie = nv & 64'h80;
            end
            if (wr && idx == `CSR_MIP) begin
                mip = nv & 64'h80;
            end else if (mtip || tmr_update) begin
                mip[7] = mtip;
            end

            st = mstatus;
            if (wr && idx == `CSR_MSTATUS) begin
                st = nv;
            end else if (trap) begin
                st[12:11] = 2'b11;
                st[7]     = mstatus[3];
                st[3]     = 1'b0;
            end else if (inst_valid_i && mret) begin
                st[12:11] = 2'b00;
                st[7]     = 1'b1;
                st[3]     = mstatus[7];
            end
            mstatus = st;

            mcycle = mcycle + 64'd1;
            if (!take) begin
                minstret = minstret + 64'd1;
            end

            tmr_update = mtimecmp_we_i;
            if (mtimecmp_we_i) begin
                mtimecmp = mtimecmp_data_i;
            end
            mtime = mtime + 64'd1;
        end
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (armed) begin
            check_value("rd_we", {63'd0, exp_rd_we}, {63'd0, rd_we_i});
            check_value("redirect", {63'd0, exp_redirect}, {63'd0, redirect_i});
            if (exp_rd_we) begin
                check_value("rd_data", exp_rd_data, rd_data_i);
            end
            if (exp_redirect) begin
                check_value("redirect_pc", exp_pc, redirect_pc_i);
            end
        end
    end

endmodule

/* tb_csr_top.sv */
`timescale 1ns/10ps
`include "riscv_csr_macros.svh"

module tb_csr_top;

    localparam logic [31:0] ecall_word  = 32'h0000_0073;
    localparam logic [31:0] ebreak_word = 32'h0010_0073;
    localparam logic [31:0] mret_word   = 32'h3020_0073;
    localparam logic [31:0] nop_word    = 32'h0000_0013;

    logic        clk;
    logic        rst;
    logic        inst_valid;
    logic [31:0] inst;
    logic [63:0] inst_addr;
    logic [63:0] rs1_data;
    logic        mtimecmp_we;
    logic [63:0] mtimecmp_data;
    logic        rd_we;
    logic [63:0] rd_data;
    logic        redirect;
    logic [63:0] redirect_pc;

    int          errors;
    int          checks;
    int          timeouts = 0;
    logic [31:0] rand_state = 32'h374c;
    logic [63:0] pc;
    logic [11:0] writable [5];
    logic [11:0] readable [10];

    always #2 clk = ~clk;

    csr_subsystem_top DUT (
        .clk             (clk),
        .rst             (rst),
        .inst_valid_i    (inst_valid),
        .inst_i          (inst),
        .inst_addr_i     (inst_addr),
        .rs1_data_i      (rs1_data),
        .mtimecmp_we_i   (mtimecmp_we),
        .mtimecmp_data_i (mtimecmp_data),
        .rd_we_o         (rd_we),
        .rd_data_o       (rd_data),
        .redirect_o      (redirect),
        .redirect_pc_o   (redirect_pc)
    );

    tb_csr_checker u_checker (
        .clk             (clk),
        .rst             (rst),
        .inst_valid_i    (inst_valid),
        .inst_i          (inst),
        .inst_addr_i     (inst_addr),
        .rs1_data_i      (rs1_data),
        .mtimecmp_we_i   (mtimecmp_we),
        .mtimecmp_data_i (mtimecmp_data),
        .rd_we_i         (rd_we),
        .rd_data_i       (rd_data),
        .redirect_i      (redirect),
        .redirect_pc_i   (redirect_pc),
        .errors_o        (errors),
        .checks_o        (checks)
    );

    function automatic logic [31:0] rand32();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        hi = rand32();
        return {hi, rand32()};
    endfunction

    function automatic logic [31:0] encode_csr(input logic [11:0] idx, input logic [2:0] f3,
                                               input logic [4:0] src, input logic [4:0] rd);
        return {idx, src, f3, rd, `OPC_SYSTEM};
    endfunction

    task automatic drive_cycle(input logic valid, input logic [31:0] word,
                               input logic [63:0] rs1, input logic cmp_we,
                               input logic [63:0] cmp_val);
        @(posedge clk);
        #1;
        inst_valid    = valid;
        inst          = word;
        inst_addr     = pc;
        rs1_data      = rs1;
        mtimecmp_we   = cmp_we;
        mtimecmp_data = cmp_val;
        pc            = pc + 64'd4;
    endtask

    task automatic csr_access(input logic [11:0] idx, input logic [2:0] f3,
                              input logic [4:0] src, input logic [4:0] rd,
                              input logic [63:0] rs1);
        drive_cycle(1'b1, encode_csr(idx, f3, src, rd), rs1, 1'b0, 64'd0);
    endtask

    // csrrs with a zero source leaves the register alone
    task automatic read_csr(input logic [11:0] idx);
        csr_access(idx, 3'b010, 5'd0, 5'd5, 64'd0);
    endtask

    task automatic issue_word(input logic [31:0] word);
        drive_cycle(1'b1, word, rand64(), 1'b0, 64'd0);
    endtask

    task automatic write_mtimecmp(input logic [63:0] value);
        drive_cycle(1'b0, nop_word, 64'd0, 1'b1, value);
    endtask

    task automatic wait_for_takeover();
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 16) begin
            // a CSR read with rd set, so the takeover must drop its writeback
            read_csr(`CSR_MSCRATCH);
            seen = redirect;
            n++;
        end
        if (!seen) begin
            $display("timeout: the pending timer interrupt was never taken");
            timeouts++;
        end
    endtask

    task automatic wait_mip_clear();
        int   n;
        logic clear;
        n     = 0;
        clear = 1'b0;
        while (!clear && n < 16) begin
            read_csr(`CSR_MIP);
            clear = rd_we && !rd_data[7];
            n++;
        end
        if (!clear) begin
            $display("timeout: mip timer bit stayed set after mtimecmp was raised");
            timeouts++;
        end
    endtask

    task automatic random_cycle();
        logic [31:0] r;
        logic [31:0] sel;
        logic [2:0]  f3;
        logic [63:0] cmp_val;
        logic        cmp_we;
        r       = rand32();
        sel     = rand32();
        cmp_we  = sel[7:4] == 4'd0;
        cmp_val = sel[8] ? {56'd0, sel[31:24]} : {32'hFFFF_FFFF, rand32()};
        f3      = {r[25], (r[27:26] == 2'b00) ? 2'b01 : r[27:26]};
        case (r[31:28])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
                drive_cycle(1'b1, encode_csr(writable[int'(sel[23:16]) % 5], f3,
                            r[19:15], r[24:20]), rand64(), cmp_we, cmp_val);
            end
            4'd6, 4'd7: begin
                drive_cycle(1'b1, encode_csr(readable[int'(sel[23:16]) % 10], 3'b010,
                            5'd0, r[24:20]), 64'd0, cmp_we, cmp_val);
            end
            // mstatus kept to MIE, MPIE and MPP
            4'd8: begin
                drive_cycle(1'b1, encode_csr(`CSR_MSTATUS, {1'b0, f3[1:0]}, 5'd0, r[24:20]),
                            rand64() & 64'h1888, cmp_we, cmp_val);
            end
            4'd9:  drive_cycle(1'b1, ecall_word, 64'd0, cmp_we, cmp_val);
            4'd10: drive_cycle(1'b1, ebreak_word, 64'd0, cmp_we, cmp_val);
            4'd11: drive_cycle(1'b1, mret_word, 64'd0, cmp_we, cmp_val);
            4'd12, 4'd13: begin
                drive_cycle(1'b1, {25'(rand32()) | 25'h1, 7'b0110011}, rand64(),
                            cmp_we, cmp_val);
            end
            default: drive_cycle(1'b0, rand32(), rand64(), cmp_we, cmp_val);
        endcase
    endtask

    initial begin
        writable      = '{`CSR_MSCRATCH, `CSR_MTVEC, `CSR_MEPC, `CSR_MIE, `CSR_MIP};
        readable      = '{`CSR_MISA, `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID,
                          `CSR_MHARTID, `CSR_MCYCLE, `CSR_MINSTRET, `CSR_MCAUSE,
                          `CSR_MSTATUS, `CSR_MEPC};
        clk           = 1'b0;
        rst           = 1'b1;
        inst_valid    = 1'b0;
        inst          = nop_word;
        inst_addr     = 64'd0;
        rs1_data      = 64'd0;
        mtimecmp_we   = 1'b0;
        mtimecmp_data = 64'd0;
        pc            = 64'h8000_0000;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // rw, rs and rc in register and immediate forms
        for (int i = 0; i < 5; i++) begin
            csr_access(writable[i], 3'b001, 5'd0, 5'd1, rand64());
            csr_access(writable[i], 3'b010, 5'd0, 5'd2, rand64());
            csr_access(writable[i], 3'b111, 5'(rand32()), 5'd3, 64'd0);
            csr_access(writable[i], 3'b101, 5'(rand32()), 5'd0, 64'd0);
            read_csr(writable[i]);
        end

        // traps and mret with MIE set beforehand
        csr_access(`CSR_MIE, 3'b001, 5'd0, 5'd0, 64'd0);
        csr_access(`CSR_MIP, 3'b001, 5'd0, 5'd0, 64'd0);
        csr_access(`CSR_MSTATUS, 3'b110, 5'd8, 5'd0, 64'd0);
        issue_word(ecall_word);
        read_csr(`CSR_MEPC);
        read_csr(`CSR_MCAUSE);
        read_csr(`CSR_MSTATUS);
        issue_word(ebreak_word);
        read_csr(`CSR_MEPC);
        read_csr(`CSR_MCAUSE);
        read_csr(`CSR_MSTATUS);
        issue_word(mret_word);
        read_csr(`CSR_MSTATUS);
        issue_word(mret_word);
        read_csr(`CSR_MSTATUS);

        for (int i = 0; i < 10; i++) begin
            read_csr(readable[i]);
        end

        // timer interrupt
        csr_access(`CSR_MSTATUS, 3'b111, 5'd8, 5'd0, 64'd0);
        csr_access(`CSR_MIP, 3'b001, 5'd0, 5'd0, 64'd0);
        write_mtimecmp(64'd0);
        csr_access(`CSR_MIE, 3'b010, 5'd0, 5'd0, 64'h80);
        csr_access(`CSR_MSTATUS, 3'b110, 5'd8, 5'd0, 64'd0);
        wait_for_takeover();
        read_csr(`CSR_MCAUSE);
        write_mtimecmp(64'hFFFF_FFFF_0000_0000);
        // idle while the update pulse lets mip fall
        drive_cycle(1'b0, nop_word, 64'd0, 1'b0, 64'd0);
        wait_mip_clear();

        for (int k = 0; k < 400; k++) begin
            random_cycle();
        end

        drive_cycle(1'b0, nop_word, 64'd0, 1'b0, 64'd0);
        drive_cycle(1'b0, nop_word, 64'd0, 1'b0, 64'd0);
        @(negedge clk);
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+.
csr_pkg.sv
csr_decode.sv
clint_timer.sv
mem_csr.sv
csr_commit.sv
csr_subsystem_top.sv
tb_csr_checker.sv
tb_csr_top.sv

/* run.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_csr_top -o sim_csr
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_csr)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Everything OK"; then
    exit 0
fi
echo "pass message not found"
exit 1
